// ==== hdl/frame_pkg.sv ====
// sizes and types shared by the capture core; FRAME_WORDS, BURST_LEN and FIFO_DEPTH must be powers of two
package frame_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------
    localparam int NUM_CAMS    = 4;
    localparam int FRAME_WORDS = 64;
    localparam int BURST_LEN   = 8;
    localparam int FIFO_DEPTH  = 16;

    // four writers plus the display reader at index NUM_CAMS
    localparam int NUM_REQ   = NUM_CAMS + 1;
    localparam int MEM_WORDS = NUM_CAMS * FRAME_WORDS;

    localparam int ADDR_W  = $clog2(MEM_WORDS);
    localparam int OFF_W   = $clog2(FRAME_WORDS);
    localparam int CAM_W   = $clog2(NUM_CAMS);
    localparam int REQ_W   = $clog2(NUM_REQ);
    localparam int BURST_W = $clog2(BURST_LEN);
    localparam int PTR_W   = $clog2(FIFO_DEPTH);
    localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);

    // --------------------------------------------------
    // payloads
    // --------------------------------------------------
    typedef struct packed {
        logic       sof;
        logic [7:0] pix;
    } pixel_t;

    // first pixel of the word sits in data[7:0]
    typedef struct packed {
        logic        sof;
        logic [31:0] data;
    } cam_word_t;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
    } mem_req_t;

    typedef struct packed {
        logic [CAM_W-1:0] chan;
    } read_req_t;

    typedef struct packed {
        logic [31:0]      data;
        logic             last;
        logic [CAM_W-1:0] chan;
    } frame_word_t;

endpackage

// ==== hdl/stream_fifo.sv ====
// single-clock FIFO, FIFO_DEPTH must be a power of two, out_data is valid only while out_valid is high
`timescale 1ns/10ps

module stream_fifo import frame_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic             ddr_clk,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  payload_t         in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output payload_t         out_data,
    output logic [CNT_W-1:0] count
);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // head entry shows without a register stage
    assign out_data = mem[rd_ptr];

    always_ff @(posedge ddr_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge ddr_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

// ==== hdl/pixel_packer.sv ====
// packs four pixels into a word low byte first; a sof in mid-word discards the partial word
`timescale 1ns/10ps

module pixel_packer import frame_pkg::*; (
    input  logic      ddr_clk,
    input  logic      reset,
    input  logic      pix_valid,
    output logic      pix_ready,
    input  pixel_t    pix,
    output logic      word_valid,
    input  logic      word_ready,
    output cam_word_t word
);

    logic [1:0]  byte_cnt;
    logic [23:0] acc;
    logic        acc_sof;
    logic        pix_fire;

    // hold off pixels while a full word is still waiting
    assign pix_ready = !word_valid || word_ready;
    assign pix_fire  = pix_valid && pix_ready;

    always_ff @(posedge ddr_clk) begin
        if (reset) begin
            byte_cnt   <= '0;
            acc_sof    <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (word_valid && word_ready) begin
                word_valid <= 1'b0;
            end
            if (pix_fire) begin
                if (pix.sof) begin
                    acc_sof  <= 1'b1;
                    byte_cnt <= 2'd1;
                end else if (byte_cnt == 2'd3) begin
                    word_valid <= 1'b1;
                    acc_sof    <= 1'b0;
                    byte_cnt   <= '0;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // byte lanes and the finished word
    always_ff @(posedge ddr_clk) begin
        if (pix_fire) begin
            if (pix.sof) begin
                acc[7:0] <= pix.pix;
            end else if (byte_cnt == 2'd3) begin
                word.data <= {pix.pix, acc};
                word.sof  <= acc_sof;
            end else begin
                acc[byte_cnt * 8 +: 8] <= pix.pix;
            end
        end
    end

endmodule

// ==== hdl/camera_writer.sv ====
// one camera channel writing region cam_index; word offset restarts on sof and wraps at FRAME_WORDS
`timescale 1ns/10ps

module camera_writer import frame_pkg::*; #(
    parameter int cam_index = 0
) (
    input  logic     ddr_clk,
    input  logic     reset,
    input  logic     pix_valid,
    output logic     pix_ready,
    input  pixel_t   pix,
    output logic     req,
    input  logic     grant,
    output mem_req_t mreq
);

    logic             word_valid;
    logic             word_ready;
    cam_word_t        word;
    logic             fifo_valid;
    cam_word_t        fifo_word;
    logic [CNT_W-1:0] fifo_count;
    logic [OFF_W-1:0] wr_off;
    logic [OFF_W-1:0] cur_off;

    pixel_packer u_packer (
        .ddr_clk    (ddr_clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .pix        (pix),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .word       (word)
    );

    stream_fifo #(
        .payload_t (cam_word_t)
    ) u_word_fifo (
        .ddr_clk   (ddr_clk),
        .reset     (reset),
        .in_valid  (word_valid),
        .in_ready  (word_ready),
        .in_data   (word),
        .out_valid (fifo_valid),
        .out_ready (grant),
        .out_data  (fifo_word),
        .count     (fifo_count)
    );

    // --------------------------------------------------
    // burst request and address
    // --------------------------------------------------
    // a full burst must already sit in the FIFO
    assign req = (fifo_count >= CNT_W'(BURST_LEN));

    assign cur_off = fifo_word.sof ? '0 : wr_off;

    always_comb begin
        mreq.we    = fifo_valid;
        mreq.addr  = ADDR_W'(cam_index * FRAME_WORDS) + ADDR_W'(cur_off);
        mreq.wdata = fifo_word.data;
    end

    always_ff @(posedge ddr_clk) begin
        if (reset) begin
            wr_off <= '0;
        end else if (grant && fifo_valid) begin
            wr_off <= (cur_off == OFF_W'(FRAME_WORDS - 1)) ? '0 : cur_off + 1'b1;
        end
    end

endmodule

// ==== hdl/burst_arbiter.sv ====
// round-robin burst arbiter; grant lasts BURST_LEN cycles and one idle cycle separates bursts
`timescale 1ns/10ps

module burst_arbiter import frame_pkg::*; (
    input  logic               ddr_clk,
    input  logic               reset,
    input  logic [NUM_REQ-1:0] req,
    output logic [NUM_REQ-1:0] grant,
    input  mem_req_t           mreq_in [NUM_REQ],
    output mem_req_t           mreq
);

    logic               busy;
    logic [REQ_W-1:0]   owner;
    logic [BURST_W-1:0] beat;
    logic               pick_found;
    logic [REQ_W-1:0]   pick_idx;

    // search starts just after the last owner
    always_comb begin
        int idx;
        pick_found = 1'b0;
        pick_idx   = owner;
        for (int i = 1; i <= NUM_REQ; i++) begin
            idx = int'(owner) + i;
            if (idx >= NUM_REQ) begin
                idx = idx - NUM_REQ;
            end
            if (!pick_found && req[idx]) begin
                pick_found = 1'b1;
                pick_idx   = REQ_W'(idx);
            end
        end
    end

    // --------------------------------------------------
    // burst sequencing
    // --------------------------------------------------
    // the cycle with busy low is the idle gap
    always_ff @(posedge ddr_clk) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= REQ_W'(NUM_REQ - 1);
            beat  <= '0;
        end else if (busy) begin
            beat <= beat + 1'b1;
            if (beat == BURST_W'(BURST_LEN - 1)) begin
                busy <= 1'b0;
            end
        end else if (pick_found) begin
            busy  <= 1'b1;
            owner <= pick_idx;
            beat  <= '0;
        end
    end

    always_comb begin
        grant = '0;
        if (busy) begin
            grant[owner] = 1'b1;
        end
    end

    // idle port sees a read with we low
    assign mreq = busy ? mreq_in[owner] : '0;

endmodule

// ==== hdl/frame_store.sv ====
// on-chip store for all frames, no reset on contents; a read during a write returns the old word
`timescale 1ns/10ps

module frame_store import frame_pkg::*; (
    input  logic        ddr_clk,
    input  mem_req_t    mreq,
    output logic [31:0] rdata
);

    logic [31:0] mem [MEM_WORDS];

    // region c spans c*FRAME_WORDS upward
    always_ff @(posedge ddr_clk) begin
        if (mreq.we) begin
            mem[mreq.addr] <= mreq.wdata;
        end
        rdata <= mem[mreq.addr];
    end

endmodule

// ==== hdl/display_reader.sv ====
// streams one whole frame per request; req_ready returns only after the last word leaves the output
`timescale 1ns/10ps

module display_reader import frame_pkg::*; (
    input  logic        ddr_clk,
    input  logic        reset,
    input  logic        req_valid,
    output logic        req_ready,
    input  read_req_t   read_req,
    output logic        req,
    input  logic        grant,
    output mem_req_t    mreq,
    input  logic [31:0] rdata,
    output logic        out_valid,
    input  logic        out_ready,
    output frame_word_t frame_out
);

    logic             busy;
    logic [CAM_W-1:0] chan;
    logic [OFF_W:0]   issue_cnt;
    logic [OFF_W:0]   ret_cnt;
    logic [OFF_W:0]   in_flight;
    logic             grant_d;
    logic             push;
    logic             push_ready;
    frame_word_t      push_word;
    logic [CNT_W-1:0] fifo_count;

    assign req_ready = !busy;
    assign in_flight = issue_cnt - ret_cnt;

    // --------------------------------------------------
    // read burst issue
    // --------------------------------------------------
    // reserve room for words already issued plus one more burst
    assign req = busy && (int'(issue_cnt) < FRAME_WORDS) &&
                 (int'(fifo_count) + int'(in_flight) + BURST_LEN <= FIFO_DEPTH);

    always_comb begin
        mreq.we    = 1'b0;
        mreq.addr  = ADDR_W'(int'(chan) * FRAME_WORDS + int'(issue_cnt[OFF_W-1:0]));
        mreq.wdata = '0;
    end

    // read data lands one cycle behind the grant
    assign push = grant_d && push_ready;

    always_comb begin
        push_word.data = rdata;
        push_word.last = (int'(ret_cnt) == FRAME_WORDS - 1);
        push_word.chan = chan;
    end

    always_ff @(posedge ddr_clk) begin
        if (reset) begin
            busy      <= 1'b0;
            chan      <= '0;
            issue_cnt <= '0;
            ret_cnt   <= '0;
            grant_d   <= 1'b0;
        end else begin
            grant_d <= grant;
            if (req_valid && req_ready) begin
                busy      <= 1'b1;
                chan      <= read_req.chan;
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end else begin
                if (grant) begin
                    issue_cnt <= issue_cnt + 1'b1;
                end
                if (push) begin
                    ret_cnt <= ret_cnt + 1'b1;
                end
                if (out_valid && out_ready && frame_out.last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    stream_fifo #(
        .payload_t (frame_word_t)
    ) u_out_fifo (
        .ddr_clk   (ddr_clk),
        .reset     (reset),
        .in_valid  (push),
        .in_ready  (push_ready),
        .in_data   (push_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (frame_out),
        .count     (fifo_count)
    );

endmodule

// ==== hdl/quad_capture_top.sv ====
// four-camera capture core on one clock; memory holds one frame per channel, contents undefined after reset
`timescale 1ns/10ps

module quad_capture_top import frame_pkg::*; (
    input  logic                  ddr_clk,
    input  logic                  reset,
    input  logic [NUM_CAMS-1:0]   pix_valid,
    output logic [NUM_CAMS-1:0]   pix_ready,
    input  pixel_t [NUM_CAMS-1:0] pix,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  read_req_t             read_req,
    output logic                  out_valid,
    input  logic                  out_ready,
    output frame_word_t           frame_out
);

    logic [NUM_REQ-1:0] arb_req;
    logic [NUM_REQ-1:0] arb_grant;
    mem_req_t           req_bus [NUM_REQ];
    mem_req_t           mem_req;
    logic [31:0]        mem_rdata;

    // --------------------------------------------------
    // camera channels
    // --------------------------------------------------
    for (genvar c = 0; c < NUM_CAMS; c++) begin : g_cam
        camera_writer #(
            .cam_index (c)
        ) u_writer (
            .ddr_clk   (ddr_clk),
            .reset     (reset),
            .pix_valid (pix_valid[c]),
            .pix_ready (pix_ready[c]),
            .pix       (pix[c]),
            .req       (arb_req[c]),
            .grant     (arb_grant[c]),
            .mreq      (req_bus[c])
        );
    end

    // --------------------------------------------------
    // shared memory port
    // --------------------------------------------------
    burst_arbiter u_arbiter (
        .ddr_clk (ddr_clk),
        .reset   (reset),
        .req     (arb_req),
        .grant   (arb_grant),
        .mreq_in (req_bus),
        .mreq    (mem_req)
    );

    frame_store u_store (
        .ddr_clk (ddr_clk),
        .mreq    (mem_req),
        .rdata   (mem_rdata)
    );

    // reader takes the last arbiter slot
    display_reader u_reader (
        .ddr_clk   (ddr_clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .read_req  (read_req),
        .req       (arb_req[NUM_CAMS]),
        .grant     (arb_grant[NUM_CAMS]),
        .mreq      (req_bus[NUM_CAMS]),
        .rdata     (mem_rdata),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .frame_out (frame_out)
    );

endmodule

// ==== include/tb_util.svh ====
// testbench helpers, included inside the testbench module after lfsr_state, err_count and check_count
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// --------------------------------------------------
// random bits
// --------------------------------------------------
// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one LFSR step per bit, newest bit lands in v[0]
task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
endtask

// --------------------------------------------------
// compare
// --------------------------------------------------
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
        $display("[FAIL] t=%0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
        err_count++;
    end
endtask

`endif

// ==== tb/tb_quad_capture.sv ====
// testbench for quad_capture_top; reads run only after writes have drained so the two never overlap
`timescale 1ns/10ps

module tb_quad_capture import frame_pkg::*; ();

    logic                  ddr_clk;
    logic                  reset;
    logic [NUM_CAMS-1:0]   pix_valid;
    logic [NUM_CAMS-1:0]   pix_ready;
    pixel_t [NUM_CAMS-1:0] pix;
    logic                  req_valid;
    logic                  req_ready;
    read_req_t             read_req;
    logic                  out_valid;
    logic                  out_ready;
    frame_word_t           frame_out;

    logic [15:0] lfsr_state;
    int          err_count;
    int          check_count;
    int          test_start_errs;
    int          cycle_count;

    // reference model with one packer state and one region per channel
    logic [31:0] model [NUM_CAMS][FRAME_WORDS];
    logic [31:0] pk_acc [NUM_CAMS];
    int          pk_cnt [NUM_CAMS];
    bit          pk_sof [NUM_CAMS];
    int          wr_off [NUM_CAMS];
    int          feed_len [NUM_CAMS];
    int          feed_sof2 [NUM_CAMS];

    `include "tb_util.svh"

    quad_capture_top dut0 (
        .ddr_clk   (ddr_clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix       (pix),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .read_req  (read_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .frame_out (frame_out)
    );

    initial ddr_clk = 1'b0;
    always #2 ddr_clk = ~ddr_clk;

    // limit is five tests of up to 4000 cycles times two
    always @(posedge ddr_clk) begin
        cycle_count++;
        if (cycle_count >= 2 * 5 * 4000) begin
            $display("timeout: run did not finish within %0d cycles", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    // --------------------------------------------------
    // model update on each accepted pixel
    // --------------------------------------------------
    task automatic model_accept(input int c, input pixel_t p);
        if (p.sof) begin
            pk_acc[c] = {24'h0, p.pix};
            pk_cnt[c] = 1;
            pk_sof[c] = 1'b1;
        end else begin
            pk_acc[c][pk_cnt[c] * 8 +: 8] = p.pix;
            pk_cnt[c]++;
            if (pk_cnt[c] == 4) begin
                if (pk_sof[c]) begin
                    wr_off[c] = 0;
                end
                model[c][wr_off[c]] = pk_acc[c];
                wr_off[c] = (wr_off[c] + 1) % FRAME_WORDS;
                pk_cnt[c] = 0;
                pk_sof[c] = 1'b0;
            end
        end
    endtask

    // sof on pixel 0 and on feed_sof2; valid holds until the pixel is taken
    task automatic feed_pixels(input bit gaps);
        int          idx [NUM_CAMS];
        bit          took [NUM_CAMS];
        bit          pending;
        logic [31:0] r;
        for (int c = 0; c < NUM_CAMS; c++) begin
            idx[c] = 0;
        end
        pending = 1'b1;
        @(posedge ddr_clk);
        #1;
        while (pending) begin
            for (int c = 0; c < NUM_CAMS; c++) begin
                if (idx[c] < feed_len[c] && !pix_valid[c]) begin
                    r = 32'h1;
                    if (gaps) begin
                        take_bits(2, r);
                    end
                    if (r[1:0] != 2'b00) begin
                        take_bits(8, r);
                        pix[c].pix   = r[7:0];
                        pix[c].sof   = (idx[c] == 0) || (idx[c] == feed_sof2[c]);
                        pix_valid[c] = 1'b1;
                    end
                end
            end
            #2;
            for (int c = 0; c < NUM_CAMS; c++) begin
                took[c] = pix_valid[c] && pix_ready[c];
                if (took[c]) begin
                    model_accept(c, pix[c]);
                    idx[c]++;
                end
            end
            @(posedge ddr_clk);
            #1;
            pending = 1'b0;
            for (int c = 0; c < NUM_CAMS; c++) begin
                if (took[c]) begin
                    pix_valid[c] = 1'b0;
                end
                pending = pending || (idx[c] < feed_len[c]);
            end
        end
        for (int c = 0; c < NUM_CAMS; c++) begin
            feed_len[c]  = 0;
            feed_sof2[c] = -1;
        end
    endtask

    // --------------------------------------------------
    // frame readback
    // --------------------------------------------------
    task automatic read_frame(input int ch, input bit rand_ready);
        int          idx;
        bit          accepted;
        logic [31:0] r;
        @(posedge ddr_clk);
        #1;
        read_req.chan = ch[CAM_W-1:0];
        req_valid     = 1'b1;
        accepted      = 1'b0;
        while (!accepted) begin
            #2;
            accepted = req_ready;
            @(posedge ddr_clk);
            #1;
        end
        req_valid = 1'b0;
        idx       = 0;
        while (idx < FRAME_WORDS) begin
            r = 32'h1;
            if (rand_ready) begin
                take_bits(1, r);
            end
            out_ready = r[0];
            #2;
            check_value("req_ready", 32'd0, req_ready);
            if (out_valid && out_ready) begin
                check_value("frame_out.data", model[ch][idx], frame_out.data);
                check_value("frame_out.last", idx == FRAME_WORDS - 1, frame_out.last);
                check_value("frame_out.chan", ch, frame_out.chan);
                idx++;
            end
            @(posedge ddr_clk);
            #1;
        end
        out_ready = 1'b0;
        check_value("req_ready", 32'd1, req_ready);
        check_value("out_valid", 32'd0, out_valid);
    endtask

    task automatic read_all(input bit rand_ready);
        repeat (200) @(posedge ddr_clk);
        for (int c = 0; c < NUM_CAMS; c++) begin
            read_frame(c, rand_ready);
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (err_count == test_start_errs) ? "ok" : "failed", err_count - test_start_errs);
        test_start_errs = err_count;
    endtask

    initial begin
        reset     = 1'b1;
        pix_valid = '0;
        pix       = '0;
        req_valid = 1'b0;
        read_req  = '0;
        out_ready = 1'b0;
        lfsr_state      = 16'd51333;
        err_count       = 0;
        check_count     = 0;
        test_start_errs = 0;
        cycle_count     = 0;
        for (int c = 0; c < NUM_CAMS; c++) begin
            pk_cnt[c]    = 0;
            pk_sof[c]    = 1'b0;
            wr_off[c]    = 0;
            feed_len[c]  = 0;
            feed_sof2[c] = -1;
        end
        repeat (16) @(posedge ddr_clk);
        #1;
        reset = 1'b0;
        #2;
        check_value("pix_ready", 32'hf, pix_ready);
        check_value("req_ready", 32'd1, req_ready);
        check_value("out_valid", 32'd0, out_valid);

        for (int c = 0; c < NUM_CAMS; c++) begin
            feed_len[c] = 4 * FRAME_WORDS;
            feed_pixels(1'b0);
        end
        read_all(1'b0);
        end_test(1, "one frame per channel");

        for (int c = 0; c < NUM_CAMS; c++) begin
            feed_len[c] = 4 * FRAME_WORDS;
        end
        feed_pixels(1'b1);
        read_all(1'b0);
        end_test(2, "concurrent writers");

        // 96 words so offsets 0 to 31 get overwritten
        feed_len[1] = 6 * FRAME_WORDS;
        feed_pixels(1'b1);
        read_all(1'b0);
        end_test(3, "frame wrap");

        // 24 words, then a new sof and 16 more
        feed_len[2]  = 4 * 40;
        feed_sof2[2] = 4 * 24;
        feed_pixels(1'b1);
        read_all(1'b0);
        end_test(4, "sof restart");

        read_all(1'b1);
        end_test(5, "output back-pressure");

        $display("done: 5 tests, %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
hdl/frame_pkg.sv
hdl/stream_fifo.sv
hdl/pixel_packer.sv
hdl/camera_writer.sv
hdl/burst_arbiter.sv
hdl/frame_store.sv
hdl/display_reader.sv
hdl/quad_capture_top.sv
tb/tb_quad_capture.sv

// ==== Makefile ====
# Verilator build and run for the quad capture testbench

VERILATOR ?= verilator
TOP       ?= tb_quad_capture
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(FILELIST) $(wildcard hdl/*.sv tb/*.sv include/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
